/* cpu_core.f */
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/fetch_unit.sv
hdl/data_mem.sv
hdl/control_unit.sv
hdl/cpu_core.sv
test/tb_cpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cpu_core -f cpu_core.f
./obj_dir/Vtb_cpu_core | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without a reported failure"

/* test/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core import isa_pkg::*, datapath_pkg::*; ();

	localparam int TIMEOUT = 2000;			// Cycles allowed per wait

	logic        clk;
	logic        rst_n;
	logic        resume;
	logic        in_valid;
	logic [31:0] in_data;
	logic        prog_we;
	logic [31:0] prog_addr;
	logic [31:0] prog_data;
	logic [31:0] out_data;
	logic        out_write;
	logic        halted;
	logic        waiting_input;
	logic [31:0] pc;

	logic [31:0] prog [0:255];
	logic [31:0] model_reg [0:31];			// Register file as the program should leave it
	logic [31:0] model_mem [0:255];
	logic [31:0] exp_vals [0:127];			// Expected out values in order
	logic [31:0] exp_head;
	logic [31:0] in_value;
	logic        exp_left;
	logic        timed_out = 1'b0;
	integer      seed;
	int          prog_len = 0;
	int          exp_cnt = 0;
	int          out_idx = 0;
	int          data_errs = 0;
	int          stall_errs = 0;
	int          timeouts = 0;
	int          total;

	funct_t r_fns [0:17] = '{FN_ADD, FN_SUB, FN_MUL, FN_DIV, FN_MOD, FN_AND, FN_OR, FN_XOR,
		FN_LAND, FN_LOR, FN_SLL, FN_SRL, FN_EQ, FN_NE, FN_LT, FN_LE, FN_GT, FN_GE};
	opcode_t i_ops [0:11] = '{OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI, OP_ANDI, OP_ORI,
		OP_XORI, OP_LANDI, OP_LORI, OP_SLLI, OP_SRLI};

	cpu_core #(
		.IMEM_DEPTH(256),
		.DMEM_DEPTH(256)
	) uut (
		.i_clk(clk), .i_rst_n(rst_n), .i_resume(resume), .i_in_valid(in_valid),
		.i_in_data(in_data), .i_prog_we(prog_we), .i_prog_addr(prog_addr),
		.i_prog_data(prog_data), .o_out_data(out_data), .o_out_write(out_write),
		.o_halted(halted), .o_waiting_input(waiting_input), .o_pc(pc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assign exp_head = exp_vals[out_idx[6:0]];
	assign exp_left = (out_idx < exp_cnt);

	always @(posedge clk) begin
		if (rst_n && out_write) begin
			out_idx <= out_idx + 1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		out_write |-> (exp_left && out_data == exp_head))
		else begin
			data_errs++;
			$display("Fail at %0t ns: out data %h, expected %h", $time,
				$sampled(out_data), $sampled(exp_head));
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(halted || waiting_input) |=> $stable(pc))
		else begin
			stall_errs++;
			$display("PC moved at %0t ns while the core was stalled", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(waiting_input && !in_valid) |=> (waiting_input || in_valid))
		else begin
			stall_errs++;
			$display("Input wait ended at %0t ns before the switch was set", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(halted && !resume) |=> (halted || resume))
		else begin
			stall_errs++;
			$display("Halt ended at %0t ns without a resume", $time);
		end

	function automatic logic [15:0] rand16();
		logic [31:0] v;
		v = $random(seed);
		return v[15:0];
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic logic [31:0] r_word(input funct_t fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		logic [31:0] w;
		w = '0;
		w[OP_MSB -: 6]      = OP_RTYPE;
		w[RS_LSB +: 5]      = rs;
		w[RT_LSB +: 5]      = rt;
		w[RD_LSB +: 5]      = rd;
		w[5:0]              = fn;
		return w;
	endfunction

	function automatic logic [31:0] i_word(input opcode_t op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		logic [31:0] w;
		w = '0;
		w[OP_MSB -: 6]  = op;
		w[RS_LSB +: 5]  = rs;
		w[RT_LSB +: 5]  = rt;
		w[IMM_W-1:0]    = imm;
		return w;
	endfunction

	function automatic logic [31:0] j_word(input opcode_t op, input logic [25:0] addr);
		logic [31:0] w;
		w = '0;
		w[OP_MSB -: 6]    = op;
		w[JADDR_W-1:0]    = addr;
		return w;
	endfunction

	// Expected result of each operation, straight from the ISA rules
	function automatic logic [31:0] rule_value(input funct_t fn, input logic [31:0] a,
		input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic [31:0]        r;
		sa = a;
		sb = b;
		r  = '0;
		case (fn)
			FN_ADD:  r = a + b;
			FN_SUB:  r = a - b;
			FN_MUL:  r = a * b;
			FN_DIV:  if (b != '0) r = sa / sb;		// Zero divisor gives 0
			FN_MOD:  if (b != '0) r = sa % sb;
			FN_AND:  r = a & b;
			FN_OR:   r = a | b;
			FN_XOR:  r = a ^ b;
			FN_LAND: r = {31'd0, (a != '0) && (b != '0)};
			FN_LOR:  r = {31'd0, (a != '0) || (b != '0)};
			FN_SLL:  r = a << b[4:0];
			FN_SRL:  r = a >> b[4:0];
			FN_EQ:   r = {31'd0, sa == sb};
			FN_NE:   r = {31'd0, sa != sb};
			FN_LT:   r = {31'd0, sa < sb};
			FN_LE:   r = {31'd0, sa <= sb};
			FN_GT:   r = {31'd0, sa > sb};
			FN_GE:   r = {31'd0, sa >= sb};
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic funct_t imm_funct(input opcode_t op);
		case (op)
			OP_SUBI:  return FN_SUB;
			OP_MULI:  return FN_MUL;
			OP_DIVI:  return FN_DIV;
			OP_MODI:  return FN_MOD;
			OP_ANDI:  return FN_AND;
			OP_ORI:   return FN_OR;
			OP_XORI:  return FN_XOR;
			OP_LANDI: return FN_LAND;
			OP_LORI:  return FN_LOR;
			OP_SLLI:  return FN_SLL;
			OP_SRLI:  return FN_SRL;
			default:  return FN_ADD;
		endcase
	endfunction

	task automatic emit_word(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic run_rtype(input funct_t fn, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt);
		emit_word(r_word(fn, rd, rs, rt));
		model_reg[rd] = rule_value(fn, model_reg[rs], model_reg[rt]);
		model_reg[0]  = '0;
	endtask

	task automatic run_itype(input opcode_t op, input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] imm);
		logic [31:0] a;
		logic [31:0] ea;
		a  = model_reg[rs];
		ea = a + sext16(imm);				// Data address for lw and sw
		emit_word(i_word(op, rt, rs, imm));
		case (op)
			OP_LI:   model_reg[rt] = sext16(imm);
			OP_LA:   model_reg[rt] = ea;
			OP_MOV:  model_reg[rt] = a;
			OP_NOT:  model_reg[rt] = ~a;
			OP_LW:   model_reg[rt] = model_mem[ea[7:0]];
			OP_SW:   model_mem[ea[7:0]] = model_reg[rt];
			default: model_reg[rt] = rule_value(imm_funct(op), a, sext16(imm));
		endcase
		model_reg[0] = '0;
	endtask

	task automatic check_out(input logic [4:0] rs);
		emit_word(i_word(OP_OUT, 5'd0, rs, 16'h0000));
		exp_vals[exp_cnt] = model_reg[rs];
		exp_cnt++;
	endtask

	task automatic rtype_out(input funct_t fn, input logic [4:0] rs, input logic [4:0] rt);
		run_rtype(fn, 5'd4, rs, rt);
		check_out(5'd4);
	endtask

	task automatic build_program();
		int here;
		for (int k = 0; k < 32; k++) begin
			model_reg[k] = '0;
		end
		run_itype(OP_LI, 5'd1, 5'd0, rand16() & 16'h7fff);			// Positive operands
		run_itype(OP_LI, 5'd2, 5'd0, (rand16() & 16'h7fff) | 16'h0001);
		run_itype(OP_LI, 5'd3, 5'd0, 16'h0000);
		run_itype(OP_LI, 5'd15, 5'd0, rand16() | 16'h8000);		// Negative operand
		for (int k = 0; k < 18; k++) begin
			rtype_out(r_fns[k], 5'd1, 5'd2);
		end
		rtype_out(FN_DIV, 5'd1, 5'd3);
		rtype_out(FN_MOD, 5'd1, 5'd3);
		rtype_out(FN_DIV, 5'd15, 5'd2);
		rtype_out(FN_MOD, 5'd15, 5'd2);
		rtype_out(FN_EQ, 5'd1, 5'd1);
		rtype_out(FN_LE, 5'd1, 5'd1);
		rtype_out(FN_GE, 5'd1, 5'd1);
		rtype_out(FN_LAND, 5'd1, 5'd3);
		rtype_out(FN_LOR, 5'd3, 5'd3);
		rtype_out(FN_LT, 5'd15, 5'd1);
		rtype_out(FN_GT, 5'd15, 5'd1);
		for (int k = 0; k < 12; k++) begin
			run_itype(i_ops[k], 5'd4, 5'd1, (rand16() & 16'h7fff) | 16'h0001);
			check_out(5'd4);
		end
		run_itype(OP_DIVI, 5'd4, 5'd1, 16'h0000);
		check_out(5'd4);
		run_itype(OP_MODI, 5'd4, 5'd1, 16'h0000);
		check_out(5'd4);
		run_itype(OP_NOT, 5'd4, 5'd1, 16'h0000);
		check_out(5'd4);

		// Store four random words off a base, then read them back
		run_itype(OP_LI, 5'd7, 5'd0, 16'd16);
		for (int k = 0; k < 4; k++) begin
			run_itype(OP_LI, 5'd5, 5'd0, rand16());
			run_itype(OP_SW, 5'd5, 5'd7, 16'(k * 37 + 3));
		end
		for (int k = 0; k < 4; k++) begin
			run_itype(OP_LW, 5'd6, 5'd7, 16'(k * 37 + 3));
			check_out(5'd6);
		end
		run_itype(OP_LA, 5'd8, 5'd7, 16'd5);
		check_out(5'd8);
		run_itype(OP_MOV, 5'd9, 5'd5, 16'h0000);
		check_out(5'd9);

		here = prog_len;
		emit_word(j_word(OP_J, 26'(here + 2)));
		emit_word(i_word(OP_OUT, 5'd0, 5'd1, 16'h0000));		// Must be skipped
		run_itype(OP_LI, 5'd10, 5'd0, 16'h00a5);
		check_out(5'd10);

		// Subroutine sits after the return point, so its effect is modelled first
		here = prog_len;
		emit_word(j_word(OP_JAL, 26'(here + 4)));
		model_reg[LINK_REG] = 32'(here + 1);
		model_reg[10]       = 32'd77;
		check_out(5'd10);
		check_out(LINK_REG);
		emit_word(j_word(OP_J, 26'(here + 6)));
		emit_word(i_word(OP_LI, 5'd10, 5'd0, 16'd77));
		emit_word(r_word(FN_JR, 5'd0, LINK_REG, 5'd0));

		run_itype(OP_LI, 5'd11, 5'd0, 16'h0000);
		run_itype(OP_LI, 5'd12, 5'd0, 16'h0005);
		here = prog_len;
		emit_word(i_word(OP_JF, 5'd0, 5'd11, 16'(here + 2)));	// Taken
		emit_word(i_word(OP_OUT, 5'd0, 5'd12, 16'h0000));
		check_out(5'd11);
		here = prog_len;
		emit_word(i_word(OP_JF, 5'd0, 5'd12, 16'(here + 2)));	// Falls through
		check_out(5'd12);
		check_out(5'd11);

		in_value = $random(seed);
		emit_word(i_word(OP_IN, 5'd13, 5'd0, 16'h0000));
		model_reg[13] = in_value;
		check_out(5'd13);

		emit_word(j_word(OP_HALT, 26'd0));
		run_itype(OP_LI, 5'd14, 5'd0, 16'h0bee);
		check_out(5'd14);
		here = prog_len;
		emit_word(j_word(OP_J, 26'(here)));				// Park here
	endtask

	// 0 watches the input wait, 1 the halt, 2 the number of outs seen
	function automatic int watch_value(input int sel);
		case (sel)
			0:       return int'(waiting_input);
			1:       return int'(halted);
			default: return out_idx;
		endcase
	endfunction

	task automatic wait_for(input string what, input int sel, input int target);
		int n;
		n = 0;
		if (!timed_out) begin
			do begin
				@(negedge clk);
				n++;
			end while (watch_value(sel) != target && n < TIMEOUT);
			if (watch_value(sel) != target) begin
				$display("Timeout at %0t ns: %s not reached in %0d cycles", $time, what,
					TIMEOUT);
				timeouts++;
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		seed      = 32'h5767;
		rst_n     = 1'b0;
		resume    = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		build_program();
		in_data = ~in_value;				// Stale data until the switch is set
		for (int a = 0; a < prog_len; a++) begin
			@(posedge clk);
			#2;
			prog_we   = 1'b1;
			prog_addr = 32'(a);
			prog_data = prog[a];
		end
		@(posedge clk);
		#2;
		prog_we = 1'b0;
		repeat (10) @(posedge clk);			// Reset held ten cycles past the load
		#2;
		rst_n = 1'b1;

		wait_for("input wait", 0, 1);
		repeat (4) @(posedge clk);
		#2;
		in_valid = 1'b1;
		in_data  = in_value;
		wait_for("end of input wait", 0, 0);
		@(posedge clk);
		#2;
		in_valid = 1'b0;

		wait_for("halt", 1, 1);
		repeat (4) @(posedge clk);
		#2;
		resume = 1'b1;
		wait_for("end of halt", 1, 0);
		@(posedge clk);
		#2;
		resume = 1'b0;

		wait_for("last expected out", 2, exp_cnt);
		repeat (4) @(negedge clk);

		total = data_errs + stall_errs + timeouts;
		$display("Errors: out data %0d, stall %0d, timeout %0d", data_errs, stall_errs,
			timeouts);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import isa_pkg::*, datapath_pkg::*; #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_resume,			// Level, releases halt
	input  logic              i_in_valid,		// Input switch
	input  logic [DATA_W-1:0] i_in_data,
	input  logic              i_prog_we,
	input  logic [ADDR_W-1:0] i_prog_addr,
	input  logic [DATA_W-1:0] i_prog_data,
	output logic [DATA_W-1:0] o_out_data,
	output logic              o_out_write,
	output logic              o_halted,
	output logic              o_waiting_input,
	output logic [ADDR_W-1:0] o_pc
);

	logic [DATA_W-1:0]     instr;
	logic [ADDR_W-1:0]     pc_next_seq;
	opcode_t               opcode;
	funct_t                funct;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] waddr;
	logic [IMM_W-1:0]      imm;
	logic [DATA_W-1:0]     imm_ext;
	logic [DATA_W-1:0]     rdata_a;
	logic [DATA_W-1:0]     rdata_b;
	logic [DATA_W-1:0]     alu_b;
	logic [DATA_W-1:0]     alu_result;
	logic [DATA_W-1:0]     mem_rdata;
	logic [DATA_W-1:0]     wb_data;
	logic                  alu_zero;
	logic                  reg_write;
	logic                  mem_write;
	logic                  alu_src_reg;
	logic                  rt_dest;
	logic                  is_jal;
	logic                  out_write;
	logic                  stall;
	logic                  is_halt;
	logic                  is_insert;
	logic                  commit;			// Instruction retires this cycle
	pc_src_t               pc_src;
	wb_sel_t               wb_sel;
	alu_op_t               alu_op;

	assign opcode  = opcode_t'(instr[OP_MSB -: OP_W]);
	assign funct   = funct_t'(instr[FUNCT_W-1:0]);
	assign rs      = instr[RS_LSB +: REG_ADDR_W];
	assign rt      = instr[RT_LSB +: REG_ADDR_W];
	assign rd      = instr[RD_LSB +: REG_ADDR_W];
	assign imm     = instr[IMM_W-1:0];
	assign imm_ext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

	assign commit = i_rst_n & ~stall;
	assign alu_b  = alu_src_reg ? rdata_b : imm_ext;
	assign waddr  = is_jal ? LINK_REG : (rt_dest ? rt : rd);

	always_comb begin
		case (wb_sel)
			WB_MEM:   wb_data = mem_rdata;
			WB_INPUT: wb_data = i_in_data;
			WB_LINK:  wb_data = pc_next_seq;	// Return address for jal
			default:  wb_data = alu_result;
		endcase
	end

	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_stall(stall), .i_pc_src(pc_src),
		.i_branch_addr({{(ADDR_W-IMM_W){1'b0}}, imm}),
		.i_jump_addr({{(ADDR_W-JADDR_W){1'b0}}, instr[JADDR_W-1:0]}),
		.i_reg_addr(rdata_a),
		.i_prog_we(i_prog_we), .i_prog_addr(i_prog_addr), .i_prog_data(i_prog_data),
		.o_pc(o_pc), .o_pc_next_seq(pc_next_seq), .o_instr(instr)
	);

	control_unit u_ctrl (
		.i_opcode(opcode), .i_funct(funct), .i_is_false(alu_zero),
		.i_in_valid(i_in_valid), .i_resume(i_resume),
		.o_reg_write(reg_write), .o_mem_write(mem_write), .o_alu_src_reg(alu_src_reg),
		.o_rt_dest(rt_dest), .o_is_jal(is_jal), .o_out_write(out_write),
		.o_stall(stall), .o_is_halt(is_halt), .o_is_insert(is_insert),
		.o_pc_src(pc_src), .o_wb_sel(wb_sel), .o_alu_op(alu_op)
	);

	register_file u_regs (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(reg_write & commit),
		.i_waddr(waddr), .i_wdata(wb_data),
		.i_raddr_a(rs), .i_raddr_b(rt), .o_rdata_a(rdata_a), .o_rdata_b(rdata_b)
	);

	alu u_alu (
		.i_op(alu_op), .i_a(rdata_a), .i_b(alu_b), .o_result(alu_result), .o_zero(alu_zero)
	);

	data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
		.i_clk(i_clk), .i_we(mem_write & commit), .i_addr(alu_result),
		.i_wdata(rdata_b), .o_rdata(mem_rdata)
	);

	assign o_out_data      = rdata_a;
	assign o_out_write     = out_write & i_rst_n;
	assign o_halted        = is_halt & stall & i_rst_n;		// Low once resume is seen
	assign o_waiting_input = is_insert & stall & i_rst_n;

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit import isa_pkg::*, datapath_pkg::*; (
	input  opcode_t i_opcode,
	input  funct_t  i_funct,
	input  logic    i_is_false,			// ALU zero flag
	input  logic    i_in_valid,			// Input switch
	input  logic    i_resume,			// Operator releases halt
	output logic    o_reg_write,
	output logic    o_mem_write,
	output logic    o_alu_src_reg,		// 1 selects rt, 0 the immediate
	output logic    o_rt_dest,			// 1 writes rt, 0 writes rd
	output logic    o_is_jal,
	output logic    o_out_write,
	output logic    o_stall,
	output logic    o_is_halt,
	output logic    o_is_insert,
	output pc_src_t o_pc_src,
	output wb_sel_t o_wb_sel,
	output alu_op_t o_alu_op
);

	function automatic alu_op_t funct_to_alu(funct_t fn);
		case (fn)
			FN_ADD:  return ALU_ADD;
			FN_SUB:  return ALU_SUB;
			FN_MUL:  return ALU_MUL;
			FN_DIV:  return ALU_DIV;
			FN_MOD:  return ALU_MOD;
			FN_AND:  return ALU_AND;
			FN_OR:   return ALU_OR;
			FN_XOR:  return ALU_XOR;
			FN_LAND: return ALU_LAND;
			FN_LOR:  return ALU_LOR;
			FN_SLL:  return ALU_SLL;
			FN_SRL:  return ALU_SRL;
			FN_EQ:   return ALU_EQ;
			FN_NE:   return ALU_NE;
			FN_LT:   return ALU_LT;
			FN_LE:   return ALU_LE;
			FN_GT:   return ALU_GT;
			FN_GE:   return ALU_GE;
			FN_JR:   return ALU_PASS_A;		// Target comes straight from rs
			default: return ALU_ADD;
		endcase
	endfunction

	// I-type arithmetic and logic share one control pattern
	function automatic alu_op_t imm_to_alu(opcode_t op);
		case (op)
			OP_ADDI:  return ALU_ADD;
			OP_SUBI:  return ALU_SUB;
			OP_MULI:  return ALU_MUL;
			OP_DIVI:  return ALU_DIV;
			OP_MODI:  return ALU_MOD;
			OP_ANDI:  return ALU_AND;
			OP_ORI:   return ALU_OR;
			OP_XORI:  return ALU_XOR;
			OP_NOT:   return ALU_NOT;
			OP_LANDI: return ALU_LAND;
			OP_LORI:  return ALU_LOR;
			OP_SLLI:  return ALU_SLL;
			OP_SRLI:  return ALU_SRL;
			default:  return ALU_ADD;
		endcase
	endfunction

	always_comb begin
		o_reg_write   = 1'b0;
		o_mem_write   = 1'b0;
		o_alu_src_reg = 1'b0;
		o_rt_dest     = 1'b0;
		o_is_jal      = 1'b0;
		o_out_write   = 1'b0;
		o_stall       = 1'b0;
		o_is_halt     = 1'b0;
		o_is_insert   = 1'b0;
		o_wb_sel      = WB_ALU;
		o_alu_op      = ALU_ADD;			// Address add for lw, sw, la
		case (i_opcode)
			OP_RTYPE: begin
				o_alu_op = funct_to_alu(i_funct);
				case (i_funct)
					FN_ADD, FN_SUB, FN_MUL, FN_DIV, FN_MOD, FN_AND, FN_OR, FN_XOR,
					FN_LAND, FN_LOR, FN_SLL, FN_SRL,
					FN_EQ, FN_NE, FN_LT, FN_LE, FN_GT, FN_GE: begin
						o_reg_write   = 1'b1;
						o_alu_src_reg = 1'b1;
					end
					default: ;
				endcase
			end
			OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI, OP_ANDI, OP_ORI, OP_XORI,
			OP_NOT, OP_LANDI, OP_LORI, OP_SLLI, OP_SRLI: begin
				o_reg_write = 1'b1;
				o_rt_dest   = 1'b1;
				o_alu_op    = imm_to_alu(i_opcode);
			end
			OP_MOV: begin
				o_reg_write   = 1'b1;
				o_rt_dest     = 1'b1;
				o_alu_src_reg = 1'b1;
				o_alu_op      = ALU_PASS_A;
			end
			OP_LW: begin
				o_reg_write = 1'b1;
				o_rt_dest   = 1'b1;
				o_wb_sel    = WB_MEM;
			end
			OP_LI: begin
				o_reg_write = 1'b1;
				o_rt_dest   = 1'b1;
				o_alu_op    = ALU_PASS_B;
			end
			OP_LA: begin
				o_reg_write = 1'b1;
				o_rt_dest   = 1'b1;
			end
			OP_SW:  o_mem_write = 1'b1;
			OP_IN: begin
				o_reg_write = 1'b1;
				o_rt_dest   = 1'b1;
				o_wb_sel    = WB_INPUT;
				o_is_insert = 1'b1;
				o_stall     = ~i_in_valid;		// Hold until the switch is set
			end
			OP_OUT: begin
				o_out_write = 1'b1;
				o_alu_op    = ALU_PASS_B;
			end
			OP_JF:  o_alu_op = ALU_PASS_A;		// Zero flag tests rs
			OP_JAL: begin
				o_reg_write = 1'b1;
				o_is_jal    = 1'b1;
				o_wb_sel    = WB_LINK;
			end
			OP_HALT: begin
				o_is_halt = 1'b1;
				o_stall   = ~i_resume;
			end
			default: ;
		endcase
	end

	// Kept apart from the decode since it depends on the ALU result
	always_comb begin
		case (i_opcode)
			OP_RTYPE: o_pc_src = (i_funct == FN_JR) ? PC_REG : PC_NEXT;
			OP_JF:    o_pc_src = i_is_false ? PC_BRANCH : PC_NEXT;
			OP_J, OP_JAL: o_pc_src = PC_JUMP;
			default:  o_pc_src = PC_NEXT;
		endcase
	end

	always_comb begin
		assert final (!(o_mem_write && o_reg_write))
			else $error("control_unit: register and memory write both enabled");
		assert final (o_pc_src != PC_JUMP || i_opcode inside {OP_J, OP_JAL})
			else $error("control_unit: jump source on a non-jump opcode");
	end

endmodule

/* hdl/data_mem.sv */
`timescale 1ns/1ps

module data_mem import datapath_pkg::*; #(
	parameter int DMEM_DEPTH = 256
) (
	input  logic              i_clk,
	input  logic              i_we,
	input  logic [ADDR_W-1:0] i_addr,		// Word address from the ALU
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata
);

	localparam int IDX_W = $clog2(DMEM_DEPTH);

	logic [DATA_W-1:0] mem [DMEM_DEPTH];
	logic [IDX_W-1:0]  idx;

	assign idx = i_addr[IDX_W-1:0];			// Upper bits ignored, address wraps

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[idx] <= i_wdata;
		end
	end

	assign o_rdata = mem[idx];

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import datapath_pkg::*; #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_stall,			// Hold PC on in or halt
	input  pc_src_t           i_pc_src,
	input  logic [ADDR_W-1:0] i_branch_addr,
	input  logic [ADDR_W-1:0] i_jump_addr,
	input  logic [ADDR_W-1:0] i_reg_addr,
	input  logic              i_prog_we,		// Program port, used in reset only
	input  logic [ADDR_W-1:0] i_prog_addr,
	input  logic [DATA_W-1:0] i_prog_data,
	output logic [ADDR_W-1:0] o_pc,
	output logic [ADDR_W-1:0] o_pc_next_seq,
	output logic [DATA_W-1:0] o_instr
);

	localparam int IDX_W = $clog2(IMEM_DEPTH);

	logic [DATA_W-1:0] imem [IMEM_DEPTH];
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pc_next;

	assign o_pc_next_seq = pc + ADDR_W'(1);		// Word addressed

	always_comb begin
		if (i_stall) begin
			pc_next = pc;
		end else begin
			case (i_pc_src)
				PC_BRANCH: pc_next = i_branch_addr;
				PC_REG:    pc_next = i_reg_addr;
				PC_JUMP:   pc_next = i_jump_addr;
				default:   pc_next = o_pc_next_seq;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n && i_prog_we) begin
			imem[i_prog_addr[IDX_W-1:0]] <= i_prog_data;
		end
	end

	assign o_pc    = pc;
	assign o_instr = imem[pc[IDX_W-1:0]];

	assert property (@(posedge i_clk) disable iff (!i_rst_n) i_stall |=> $stable(pc))
		else $error("fetch_unit: PC moved after a stall cycle");

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file import isa_pkg::*, datapath_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_we,
	input  logic [REG_ADDR_W-1:0] i_waddr,
	input  logic [DATA_W-1:0]     i_wdata,
	input  logic [REG_ADDR_W-1:0] i_raddr_a,
	input  logic [REG_ADDR_W-1:0] i_raddr_b,
	output logic [DATA_W-1:0]     o_rdata_a,
	output logic [DATA_W-1:0]     o_rdata_b
);

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_waddr != ZERO_REG) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	assign o_rdata_a = (i_raddr_a == ZERO_REG) ? '0 : regs[i_raddr_a];	// r0 is constant
	assign o_rdata_b = (i_raddr_b == ZERO_REG) ? '0 : regs[i_raddr_b];

	// The core must gate write enable with reset
	assert property (@(posedge i_clk) !i_rst_n |-> !i_we)
		else $error("register_file: write enabled during reset");

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu import datapath_pkg::*; (
	input  alu_op_t           i_op,
	input  logic [DATA_W-1:0] i_a,
	input  logic [DATA_W-1:0] i_b,
	output logic [DATA_W-1:0] o_result,
	output logic              o_zero		// Result is all zeros
);

	localparam int SHAMT_W = $clog2(DATA_W);

	logic signed [DATA_W-1:0] a_s;
	logic signed [DATA_W-1:0] b_s;
	logic signed [DATA_W-1:0] quot;
	logic signed [DATA_W-1:0] rem;
	logic                     b_is_zero;
	logic                     a_true;
	logic                     b_true;
	logic                     cmp;

	assign a_s       = i_a;
	assign b_s       = i_b;
	assign quot      = a_s / b_s;			// Signed, rounds toward zero
	assign rem       = a_s % b_s;			// Takes the sign of the dividend
	assign b_is_zero = (i_b == '0);
	assign a_true    = (i_a != '0);			// Nonzero counts as true
	assign b_true    = (i_b != '0);

	// Compares are signed and return a single bit
	always_comb begin
		case (i_op)
			ALU_EQ:  cmp = (a_s == b_s);
			ALU_NE:  cmp = (a_s != b_s);
			ALU_LT:  cmp = (a_s <  b_s);
			ALU_LE:  cmp = (a_s <= b_s);
			ALU_GT:  cmp = (a_s >  b_s);
			ALU_GE:  cmp = (a_s >= b_s);
			default: cmp = 1'b0;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_ADD:    o_result = i_a + i_b;
			ALU_SUB:    o_result = i_a - i_b;
			ALU_MUL:    o_result = i_a * i_b;			// Low word of product
			ALU_DIV:    o_result = b_is_zero ? '0 : quot;
			ALU_MOD:    o_result = b_is_zero ? '0 : rem;
			ALU_SLL:    o_result = i_a << i_b[SHAMT_W-1:0];
			ALU_SRL:    o_result = i_a >> i_b[SHAMT_W-1:0];	// Logical shift
			ALU_AND:    o_result = i_a & i_b;
			ALU_OR:     o_result = i_a | i_b;
			ALU_XOR:    o_result = i_a ^ i_b;
			ALU_NOT:    o_result = ~i_a;
			ALU_LAND:   o_result = {{(DATA_W-1){1'b0}}, a_true & b_true};
			ALU_LOR:    o_result = {{(DATA_W-1){1'b0}}, a_true | b_true};
			ALU_PASS_A: o_result = i_a;
			ALU_PASS_B: o_result = i_b;
			ALU_EQ, ALU_NE, ALU_LT, ALU_LE, ALU_GT, ALU_GE:
				o_result = {{(DATA_W-1){1'b0}}, cmp};
			default:    o_result = '0;
		endcase
	end

	assign o_zero = (o_result == '0);

endmodule

/* hdl/datapath_pkg.sv */
package datapath_pkg;

	localparam int DATA_W = 32;				// Machine word
	localparam int ADDR_W = 32;				// PC and memory address width

	typedef enum logic [4:0] {
		ALU_ADD    = 5'd0,  ALU_SUB  = 5'd1,  ALU_MUL  = 5'd2,  ALU_DIV = 5'd3,
		ALU_MOD    = 5'd4,  ALU_SLL  = 5'd5,  ALU_SRL  = 5'd6,
		ALU_AND    = 5'd8,  ALU_OR   = 5'd9,  ALU_XOR  = 5'd10, ALU_NOT = 5'd11,
		ALU_LAND   = 5'd12, ALU_LOR  = 5'd13,
		ALU_PASS_A = 5'd14, ALU_PASS_B = 5'd15,
		ALU_EQ     = 5'd16, ALU_NE   = 5'd17, ALU_LT   = 5'd18, ALU_LE  = 5'd19,
		ALU_GT     = 5'd20, ALU_GE   = 5'd21
	} alu_op_t;

	typedef enum logic [1:0] {
		PC_NEXT   = 2'd0,				// PC + 1
		PC_BRANCH = 2'd1,				// Immediate target of jf
		PC_REG    = 2'd2,				// Register target of jr
		PC_JUMP   = 2'd3				// 26-bit target of j and jal
	} pc_src_t;

	typedef enum logic [1:0] {
		WB_ALU   = 2'd0,
		WB_MEM   = 2'd1,
		WB_INPUT = 2'd2,
		WB_LINK  = 2'd3
	} wb_sel_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

	localparam int OP_W       = 6;				// Opcode field width
	localparam int FUNCT_W    = 6;				// Function field width
	localparam int REG_ADDR_W = 5;				// Register index width
	localparam int NUM_REGS   = 32;

	localparam int OP_MSB  = 31;				// Opcode occupies [31:26]
	localparam int RS_LSB  = 21;				// Source register rs
	localparam int RT_LSB  = 16;				// Second source or I-type destination
	localparam int RD_LSB  = 11;				// R-type destination
	localparam int IMM_W   = 16;				// I-type immediate, low bits
	localparam int JADDR_W = 26;				// J-type target, low bits

	localparam logic [REG_ADDR_W-1:0] ZERO_REG = 5'd0;	// Hardwired zero
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;	// Return address for jal

	typedef enum logic [OP_W-1:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI  = 6'd1,
		OP_SUBI  = 6'd2,
		OP_MULI  = 6'd3,
		OP_DIVI  = 6'd4,
		OP_MODI  = 6'd5,
		OP_ANDI  = 6'd6,
		OP_ORI   = 6'd7,
		OP_XORI  = 6'd8,
		OP_NOT   = 6'd9,
		OP_LANDI = 6'd10,
		OP_LORI  = 6'd11,
		OP_SLLI  = 6'd12,
		OP_SRLI  = 6'd13,
		OP_MOV   = 6'd14,				// rt <- rs
		OP_LW    = 6'd15,
		OP_LI    = 6'd16,				// rt <- imm
		OP_LA    = 6'd17,				// rt <- rs + imm
		OP_SW    = 6'd18,
		OP_IN    = 6'd19,				// Waits for the input switch
		OP_OUT   = 6'd20,
		OP_JF    = 6'd21,				// Jump if rs is false
		OP_J     = 6'd22,
		OP_JAL   = 6'd23,
		OP_HALT  = 6'd24
	} opcode_t;

	typedef enum logic [FUNCT_W-1:0] {
		FN_ADD  = 6'd0,  FN_SUB = 6'd1,  FN_MUL = 6'd2,  FN_DIV = 6'd3,
		FN_MOD  = 6'd4,  FN_AND = 6'd5,  FN_OR  = 6'd6,  FN_XOR = 6'd7,
		FN_LAND = 6'd8,  FN_LOR = 6'd9,  FN_SLL = 6'd10, FN_SRL = 6'd11,
		FN_EQ   = 6'd12, FN_NE  = 6'd13, FN_LT  = 6'd14, FN_LE  = 6'd15,
		FN_GT   = 6'd16, FN_GE  = 6'd17,
		FN_JR   = 6'd18					// Jump to rs
	} funct_t;

endpackage
